//--- hdl/cv_pkg.sv
// Shared widths, keypad codes and loader constants; key codes match the console's active-low keypad matrix
package cv_pkg;

        // ==============================
        // Widths with a meaning
        // ==============================

        // One byte of a download image
        typedef logic [7:0]  byte_t;
        // Download byte address
        typedef logic [24:0] ioctl_addr_t;
        // Image index, low 5 bits give the image kind
        typedef logic [7:0]  ioctl_index_t;
        // Count of 16 KB cartridge pages
        typedef logic [5:0]  cart_pages_t;
        // Host joystick bitmap
        // 0 right, 1 left, 2 down, 3 up, 4 fire 1, 5 fire 2, 6 *, 7 #,
        // 8..17 digits 0..9, 18 purple, 19 blue
        typedef logic [19:0] joy_t;
        // Controller port nibble
        typedef logic [3:0]  key_code_t;

        // ==============================
        // Keypad codes
        // ==============================

        localparam key_code_t KEY_0    = 4'b0011;
        localparam key_code_t KEY_1    = 4'b1110;
        localparam key_code_t KEY_2    = 4'b1101;
        localparam key_code_t KEY_3    = 4'b0110;
        localparam key_code_t KEY_4    = 4'b0001;
        localparam key_code_t KEY_5    = 4'b1001;
        localparam key_code_t KEY_6    = 4'b0111;
        localparam key_code_t KEY_7    = 4'b1100;
        localparam key_code_t KEY_8    = 4'b1000;
        localparam key_code_t KEY_9    = 4'b1011;
        localparam key_code_t KEY_AST  = 4'b1010;
        localparam key_code_t KEY_NUM  = 4'b0101;
        localparam key_code_t KEY_PT   = 4'b0100;
        localparam key_code_t KEY_BT   = 4'b0010;
        localparam key_code_t KEY_NONE = 4'b1111;

        // ==============================
        // Loader
        // ==============================

        // Image kind of an SG-1000 cartridge
        localparam logic [4:0]  SG1000_INDEX = 5'd2;
        // Address bits 24..13 of the 8 KB block at 0x2000
        localparam logic [11:0] EXTRAM_BLOCK = 12'd1;

        typedef enum logic [1:0] {
                LOAD_IDLE,
                LOAD_HEADER,
                LOAD_BODY
        } load_state_t;

endpackage

//--- hdl/cart_load_if.sv
// Download writes after the sequencer; every field is valid in the cycle wr is high
`timescale 1ns/1ps

interface cart_load_if;

        // Write strobe, one cycle per byte
        logic                   wr;
        // First write of the current download
        logic                   first;
        // SG-1000 image, valid with first
        logic                   sg_sel;
        cv_pkg::ioctl_addr_t    addr;
        cv_pkg::byte_t          data;

        modport seq (
                output wr,
                output first,
                output sg_sel,
                output addr,
                output data
        );

        modport info (
                input wr,
                input first,
                input sg_sel,
                input addr,
                input data
        );

endinterface

//--- hdl/ce_divider.sv
// Free-running divide by 4 and 8 of clk_sys; both enables are low for one cycle after reset
`timescale 1ns/1ps

module ce_divider (
        input  logic clk_sys,
        input  logic reset_i,
        output logic ce_10m7_o,
        output logic ce_5m3_o
);

        logic [2:0] div;

        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        div <= '0;
                end else begin
                        div <= div + 3'd1;
                end
        end

        // Pixel rate every fourth cycle, CPU rate every eighth
        // The 5.3 MHz pulse always lands on a 10.7 MHz pulse
        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        ce_10m7_o <= 1'b0;
                        ce_5m3_o  <= 1'b0;
                end else begin
                        ce_10m7_o <= (div[1:0] == 2'd0);
                        ce_5m3_o  <= (div == 3'd0);
                end
        end

endmodule

//--- hdl/cart_loader_fsm.sv
// Expects download_i high at least one cycle before the first write, which must have address 0
`timescale 1ns/1ps

module cart_loader_fsm (
        input  logic                   clk_sys,
        input  logic                   reset_i,
        input  logic                   download_i,
        input  logic                   ioctl_wr_i,
        input  cv_pkg::ioctl_addr_t    ioctl_addr_i,
        input  cv_pkg::byte_t          ioctl_data_i,
        input  cv_pkg::ioctl_index_t   ioctl_index_i,
        cart_load_if.seq               load,
        output logic                   console_reset_o
);

        cv_pkg::load_state_t state;
        cv_pkg::load_state_t state_next;

        // ==============================
        // Download sequencing
        // ==============================

        always_comb begin
                state_next = state;
                case (state)
                        cv_pkg::LOAD_IDLE: begin
                                if (download_i) state_next = cv_pkg::LOAD_HEADER;
                        end
                        cv_pkg::LOAD_HEADER: begin
                                if (ioctl_wr_i) state_next = cv_pkg::LOAD_BODY;
                        end
                        default: ;
                endcase
                // Dropping the download ends it from any state
                if (!download_i) state_next = cv_pkg::LOAD_IDLE;
        end

        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        state <= cv_pkg::LOAD_IDLE;
                end else begin
                        state <= state_next;
                end
        end

        // Console stays in reset for the whole download
        always_ff @(posedge clk_sys) begin
                console_reset_o <= reset_i || (state_next != cv_pkg::LOAD_IDLE);
        end

        // ==============================
        // Write forwarding
        // ==============================

        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        load.wr    <= 1'b0;
                        load.first <= 1'b0;
                end else begin
                        load.wr    <= ioctl_wr_i;
                        load.first <= ioctl_wr_i && (state == cv_pkg::LOAD_HEADER);
                end
        end

        // Payload fields follow the strobe
        always_ff @(posedge clk_sys) begin
                load.sg_sel <= (ioctl_index_i[4:0] == cv_pkg::SG1000_INDEX);
                load.addr   <= ioctl_addr_i;
                load.data   <= ioctl_data_i;
        end

endmodule

//--- hdl/cart_info.sv
// Cartridge description for the memory mapper; extra RAM is only detected on SG-1000 images
`timescale 1ns/1ps

module cart_info (
        input  logic                   clk_sys,
        input  logic                   reset_i,
        cart_load_if.info              load,
        output logic                   sg1000_o,
        output logic                   extram_o,
        output cv_pkg::cart_pages_t    cart_pages_o
);

        logic block_hit;
        logic block_start;
        logic all_ff;

        // Write falls in 0x2000..0x3FFF
        assign block_hit   = (load.addr[24:13] == cv_pkg::EXTRAM_BLOCK);
        assign block_start = (load.addr[12:0] == 13'd0);
        assign all_ff      = &load.data;

        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        cart_pages_o <= '0;
                end else if (load.wr) begin
                        // Last address written sets the page count
                        cart_pages_o <= load.addr[19:14];
                end
        end

        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        sg1000_o <= 1'b0;
                        extram_o <= 1'b0;
                end else if (load.wr) begin
                        if (load.first) begin
                                sg1000_o <= load.sg_sel;
                                extram_o <= 1'b0;
                        end else if (block_hit && sg1000_o) begin
                                // A block left at FF means the cartridge carries its own RAM
                                extram_o <= (block_start || extram_o) && all_ff;
                        end
                end
        end

endmodule

//--- hdl/cv_controller_encoder.sv
// Purely combinational; select lines are active low and an idle port reads as all ones
`timescale 1ns/1ps

module cv_controller_encoder #(
        parameter int NUM_PLAYERS = 2
) (
        input  cv_pkg::joy_t      [NUM_PLAYERS-1:0] joy_i,
        input  logic                                swap_i,
        input  logic              [NUM_PLAYERS-1:0] keypad_sel_n_i,
        input  logic              [NUM_PLAYERS-1:0] joy_sel_n_i,
        output cv_pkg::key_code_t [NUM_PLAYERS-1:0] ctrl_n_o,
        output logic              [NUM_PLAYERS-1:0] fire_n_o
);

        // Digit codes indexed by digit value
        localparam cv_pkg::key_code_t DIGIT_CODE [10] = '{
                cv_pkg::KEY_0, cv_pkg::KEY_1, cv_pkg::KEY_2, cv_pkg::KEY_3,
                cv_pkg::KEY_4, cv_pkg::KEY_5, cv_pkg::KEY_6, cv_pkg::KEY_7,
                cv_pkg::KEY_8, cv_pkg::KEY_9
        };

        // Highest-priority pressed key
        // Walks from lowest to highest priority so the last match wins
        function automatic cv_pkg::key_code_t keypad_code(input cv_pkg::joy_t joy);
                cv_pkg::key_code_t code;
                code = cv_pkg::KEY_NONE;
                if (joy[19]) code = cv_pkg::KEY_BT;
                if (joy[18]) code = cv_pkg::KEY_PT;
                if (joy[7])  code = cv_pkg::KEY_NUM;
                if (joy[6])  code = cv_pkg::KEY_AST;
                for (int d = 9; d >= 0; d--) begin
                        if (joy[8 + d]) code = DIGIT_CODE[d];
                end
                return code;
        endfunction

        cv_pkg::joy_t [NUM_PLAYERS-1:0] joy_src;

        // ==============================
        // Player swap
        // ==============================

        always_comb begin
                for (int p = 0; p < NUM_PLAYERS; p++) begin
                        joy_src[p] = swap_i ? joy_i[NUM_PLAYERS - 1 - p] : joy_i[p];
                end
        end

        // ==============================
        // Per-player encoding
        // ==============================

        for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
                cv_pkg::key_code_t key_nib;
                cv_pkg::key_code_t dir_nib;
                logic              key_fire;
                logic              dir_fire;

                always_comb begin
                        key_nib  = 4'b1111;
                        key_fire = 1'b1;
                        dir_nib  = 4'b1111;
                        dir_fire = 1'b1;

                        // Keypad half, fire 2 on the shared line
                        if (!keypad_sel_n_i[p]) begin
                                key_nib  = keypad_code(joy_src[p]);
                                key_fire = ~joy_src[p][5];
                        end

                        // Joystick half, up down left right from bit 3 to bit 0
                        if (!joy_sel_n_i[p]) begin
                                dir_nib  = ~joy_src[p][3:0];
                                dir_fire = ~joy_src[p][4];
                        end
                end

                // Both halves drive the same open-collector lines
                assign ctrl_n_o[p] = key_nib & dir_nib;
                assign fire_n_o[p] = key_fire & dir_fire;
        end

endmodule

//--- hdl/cv_io_core.sv
// Cartridge outputs settle two cycles after the last download write
`timescale 1ns/1ps

module cv_io_core #(
        parameter int NUM_PLAYERS = 2
) (
        input  logic                                clk_sys,
        input  logic                                reset_i,

        // Host download bus
        input  logic                                download_i,
        input  logic                                ioctl_wr_i,
        input  cv_pkg::ioctl_addr_t                 ioctl_addr_i,
        input  cv_pkg::byte_t                       ioctl_data_i,
        input  cv_pkg::ioctl_index_t                ioctl_index_i,

        // Host joysticks and console controller ports
        input  cv_pkg::joy_t      [NUM_PLAYERS-1:0] joy_i,
        input  logic                                swap_i,
        input  logic              [NUM_PLAYERS-1:0] keypad_sel_n_i,
        input  logic              [NUM_PLAYERS-1:0] joy_sel_n_i,
        output cv_pkg::key_code_t [NUM_PLAYERS-1:0] ctrl_n_o,
        output logic              [NUM_PLAYERS-1:0] fire_n_o,

        // Console side
        output logic                                ce_10m7_o,
        output logic                                ce_5m3_o,
        output logic                                console_reset_o,
        output logic                                sg1000_o,
        output logic                                extram_o,
        output cv_pkg::cart_pages_t                 cart_pages_o
);

        cart_load_if load_bus ();

        ce_divider u_ce_divider (
                .clk_sys   (clk_sys),
                .reset_i   (reset_i),
                .ce_10m7_o (ce_10m7_o),
                .ce_5m3_o  (ce_5m3_o)
        );

        cart_loader_fsm u_cart_loader_fsm (
                .clk_sys         (clk_sys),
                .reset_i         (reset_i),
                .download_i      (download_i),
                .ioctl_wr_i      (ioctl_wr_i),
                .ioctl_addr_i    (ioctl_addr_i),
                .ioctl_data_i    (ioctl_data_i),
                .ioctl_index_i   (ioctl_index_i),
                .load            (load_bus),
                .console_reset_o (console_reset_o)
        );

        cart_info u_cart_info (
                .clk_sys      (clk_sys),
                .reset_i      (reset_i),
                .load         (load_bus),
                .sg1000_o     (sg1000_o),
                .extram_o     (extram_o),
                .cart_pages_o (cart_pages_o)
        );

        cv_controller_encoder #(
                .NUM_PLAYERS (NUM_PLAYERS)
        ) u_cv_controller_encoder (
                .joy_i          (joy_i),
                .swap_i         (swap_i),
                .keypad_sel_n_i (keypad_sel_n_i),
                .joy_sel_n_i    (joy_sel_n_i),
                .ctrl_n_o       (ctrl_n_o),
                .fire_n_o       (fire_n_o)
        );

endmodule

//--- tests/cv_io_core_checker.sv
// Bound into cv_io_core; properties are only meaningful after the first clock edge of the run
`timescale 1ns/1ps

module cv_io_core_checker (
        input logic clk_sys,
        input logic reset_i,
        input logic download_i,
        input logic ce_10m7_o,
        input logic ce_5m3_o,
        input logic console_reset_o
);

        // Failed properties, summed up by the testbench
        int assert_failures = 0;

        // CPU enable always lands on a pixel enable
        ce_nesting: assert property (@(posedge clk_sys) disable iff (reset_i)
                ce_5m3_o |-> ce_10m7_o)
        else begin
                $error("ce_5m3_o pulsed without ce_10m7_o");
                assert_failures++;
        end

        // Console held in reset one cycle after any download activity
        reset_on_download: assert property (@(posedge clk_sys)
                download_i |=> console_reset_o)
        else begin
                $error("console_reset_o low one cycle after download_i was high");
                assert_failures++;
        end

        // Reset forces console reset and silences both enables
        reset_state: assert property (@(posedge clk_sys)
                reset_i |=> (console_reset_o && !ce_10m7_o && !ce_5m3_o))
        else begin
                $error("console_reset_o or a clock enable wrong after reset_i");
                assert_failures++;
        end

endmodule

bind cv_io_core cv_io_core_checker u_checker (
        .clk_sys         (clk_sys),
        .reset_i         (reset_i),
        .download_i      (download_i),
        .ce_10m7_o       (ce_10m7_o),
        .ce_5m3_o        (ce_5m3_o),
        .console_reset_o (console_reset_o)
);

//--- tests/cv_io_core_tb.sv
// One download write per cycle; the SG-1000 scripts write 16 KB each, so the run is long in sim time
`timescale 1ns/1ps

module cv_io_core_tb;

        localparam int NUM_PLAYERS = 2;
        localparam int CTRL_ROWS   = 15;
        localparam int LOAD_ROWS   = 3;

        // ==============================
        // Stimulus tables
        // ==============================

        // Joystick bitmap and the keypad code it must give
        localparam logic [23:0] CTRL_TABLE [CTRL_ROWS] = '{
                {20'h00000, 4'b1111},
                {20'h00100, 4'b0011},
                {20'h00200, 4'b1110},
                {20'h00800, 4'b0110},
                {20'h01010, 4'b0001},   // digit 4 with fire 1
                {20'h02040, 4'b1001},   // digit 5 beats asterisk
                {20'h04000, 4'b0111},
                {20'h08000, 4'b1100},
                {20'h10000, 4'b1000},
                {20'h20400, 4'b1101},   // digit 2 beats digit 9
                {20'h000C0, 4'b1010},
                {20'h80080, 4'b0101},
                {20'hC0000, 4'b0100},
                {20'h80029, 4'b0010},   // blue, fire 2, up and right
                {20'h00036, 4'b1111}
        };

        // Download scripts as image index, last address and fill kind
        // Every script writes FF over 0x2000..0x3FFF and fill kind 1 adds one non-FF byte there
        localparam cv_pkg::ioctl_index_t LOAD_INDEX [LOAD_ROWS] = '{8'h00, 8'h02, 8'h22};
        localparam cv_pkg::ioctl_addr_t  LOAD_LAST  [LOAD_ROWS] = '{25'h0BFFF, 25'h03FFF, 25'h03FFF};
        localparam logic                 LOAD_FILL  [LOAD_ROWS] = '{1'b0, 1'b0, 1'b1};

        logic                                clk_sys;
        logic                                reset_i;
        logic                                download_i;
        logic                                ioctl_wr_i;
        cv_pkg::ioctl_addr_t                 ioctl_addr_i;
        cv_pkg::byte_t                       ioctl_data_i;
        cv_pkg::ioctl_index_t                ioctl_index_i;
        cv_pkg::joy_t      [NUM_PLAYERS-1:0] joy_i;
        logic                                swap_i;
        logic              [NUM_PLAYERS-1:0] keypad_sel_n_i;
        logic              [NUM_PLAYERS-1:0] joy_sel_n_i;
        cv_pkg::key_code_t [NUM_PLAYERS-1:0] ctrl_n_o;
        logic              [NUM_PLAYERS-1:0] fire_n_o;
        logic                                ce_10m7_o;
        logic                                ce_5m3_o;
        logic                                console_reset_o;
        logic                                sg1000_o;
        logic                                extram_o;
        cv_pkg::cart_pages_t                 cart_pages_o;

        integer seed;
        int     checks;
        int     errors;

        cv_io_core #(
                .NUM_PLAYERS (NUM_PLAYERS)
        ) uut (
                .clk_sys         (clk_sys),
                .reset_i         (reset_i),
                .download_i      (download_i),
                .ioctl_wr_i      (ioctl_wr_i),
                .ioctl_addr_i    (ioctl_addr_i),
                .ioctl_data_i    (ioctl_data_i),
                .ioctl_index_i   (ioctl_index_i),
                .joy_i           (joy_i),
                .swap_i          (swap_i),
                .keypad_sel_n_i  (keypad_sel_n_i),
                .joy_sel_n_i     (joy_sel_n_i),
                .ctrl_n_o        (ctrl_n_o),
                .fire_n_o        (fire_n_o),
                .ce_10m7_o       (ce_10m7_o),
                .ce_5m3_o        (ce_5m3_o),
                .console_reset_o (console_reset_o),
                .sg1000_o        (sg1000_o),
                .extram_o        (extram_o),
                .cart_pages_o    (cart_pages_o)
        );

        initial begin
                clk_sys = 1'b0;
                forever #50 clk_sys = ~clk_sys;
        end

        // ==============================
        // Helpers
        // ==============================

        task automatic expect_value(input string name, input logic [31:0] got,
                                    input logic [31:0] exp);
                checks++;
                assert (got === exp) else begin
                        $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
                        errors++;
                end
        endtask

        function automatic cv_pkg::byte_t fill_byte(input logic fill,
                                                    input cv_pkg::ioctl_addr_t addr,
                                                    input logic [12:0] bad_off,
                                                    input cv_pkg::byte_t bad_val);
                logic in_block;
                in_block = (addr >= 25'h02000) && (addr < 25'h04000);
                if (in_block) begin
                        if (fill && addr[12:0] == bad_off)
                                return bad_val;
                        return 8'hFF;
                end
                // Outside the block the byte folds in every address bit
                return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ {7'd0, addr[24]};
        endfunction

        // Enables are low on the release edge, then pulse every 4 and every 8 cycles
        task automatic enable_sequence();
                expect_value("ce_10m7_o at reset release", 32'(ce_10m7_o), 32'(0));
                expect_value("ce_5m3_o at reset release", 32'(ce_5m3_o), 32'(0));
                for (int i = 0; i < 24; i++) begin
                        @(negedge clk_sys);
                        expect_value($sformatf("ce_10m7_o cycle %0d", i), 32'(ce_10m7_o),
                                     32'(i % 4 == 0));
                        expect_value($sformatf("ce_5m3_o cycle %0d", i), 32'(ce_5m3_o),
                                     32'(i % 8 == 0));
                end
        endtask

        task automatic controller_sweep();
                int           src;
                int           rows [2];
                logic [19:0]  joy;
                logic [3:0]   exp_nib;
                logic         exp_fire;
                for (int r = 0; r < CTRL_ROWS; r++) begin
                        for (int sw = 0; sw < 2; sw++) begin
                                for (int m = 0; m < 4; m++) begin
                                        rows[0] = r;
                                        rows[1] = (r + 5) % CTRL_ROWS;
                                        @(negedge clk_sys);
                                        joy_i[0]       = CTRL_TABLE[rows[0]][23:4];
                                        joy_i[1]       = CTRL_TABLE[rows[1]][23:4];
                                        swap_i         = sw[0];
                                        keypad_sel_n_i = {NUM_PLAYERS{~m[0]}};
                                        joy_sel_n_i    = {NUM_PLAYERS{~m[1]}};
                                        @(posedge clk_sys);
                                        for (int p = 0; p < NUM_PLAYERS; p++) begin
                                                src      = rows[p ^ sw];
                                                joy      = CTRL_TABLE[src][23:4];
                                                exp_nib  = 4'hF;
                                                exp_fire = 1'b1;
                                                // Keypad and joystick halves are ANDed
                                                if (m[0]) begin
                                                        exp_nib  = exp_nib & CTRL_TABLE[src][3:0];
                                                        exp_fire = exp_fire & ~joy[5];
                                                end
                                                if (m[1]) begin
                                                        exp_nib  = exp_nib & ~joy[3:0];
                                                        exp_fire = exp_fire & ~joy[4];
                                                end
                                                expect_value($sformatf("ctrl_n_o[%0d] row %0d", p, r),
                                                             32'(ctrl_n_o[p]), 32'(exp_nib));
                                                expect_value($sformatf("fire_n_o[%0d] row %0d", p, r),
                                                             32'(fire_n_o[p]), 32'(exp_fire));
                                        end
                                end
                        end
                end
        endtask

        task automatic run_download(input int s);
                cv_pkg::ioctl_addr_t last;
                logic [31:0]         rnd;
                logic [12:0]         bad_off;
                cv_pkg::byte_t       bad_val;
                logic                exp_sg;
                int                  waited;
                last    = LOAD_LAST[s];
                rnd     = $random(seed);
                bad_off = rnd[12:0];
                rnd     = $random(seed);
                bad_val = (rnd[7:0] == 8'hFF) ? 8'h00 : rnd[7:0];
                exp_sg  = (LOAD_INDEX[s][4:0] == 5'd2);

                @(negedge clk_sys);
                download_i    = 1'b1;
                ioctl_index_i = LOAD_INDEX[s];
                for (int a = 0; a <= int'(last); a++) begin
                        @(negedge clk_sys);
                        expect_value("console_reset_o during download", 32'(console_reset_o),
                                     32'(1));
                        // First write has reached the registers here
                        if (a == 2) begin
                                expect_value("sg1000_o after first write", 32'(sg1000_o),
                                             32'(exp_sg));
                                expect_value("extram_o after first write", 32'(extram_o), 32'(0));
                        end
                        ioctl_wr_i   = 1'b1;
                        ioctl_addr_i = 25'(a);
                        ioctl_data_i = fill_byte(LOAD_FILL[s], 25'(a), bad_off, bad_val);
                end
                @(negedge clk_sys);
                ioctl_wr_i = 1'b0;
                @(negedge clk_sys);
                expect_value("cart_pages_o", 32'(cart_pages_o), 32'(last[19:14]));
                expect_value("sg1000_o", 32'(sg1000_o), 32'(exp_sg));
                expect_value("extram_o", 32'(extram_o), 32'(exp_sg && !LOAD_FILL[s]));

                download_i = 1'b0;
                waited = 0;
                while (console_reset_o && waited < 8) begin
                        @(negedge clk_sys);
                        waited++;
                end
                checks++;
                assert (!console_reset_o) else begin
                        $display("Timeout: console_reset_o still high 8 cycles after download %0d",
                                 s);
                        errors++;
                end
        endtask

        // ==============================
        // Main sequence
        // ==============================

        initial begin
                seed           = 32'hcfad;
                checks         = 0;
                errors         = 0;
                reset_i        = 1'b1;
                download_i     = 1'b0;
                ioctl_wr_i     = 1'b0;
                ioctl_addr_i   = '0;
                ioctl_data_i   = '0;
                ioctl_index_i  = '0;
                joy_i          = '0;
                swap_i         = 1'b0;
                keypad_sel_n_i = '1;
                joy_sel_n_i    = '1;

                repeat (10) @(posedge clk_sys);
                @(negedge clk_sys);
                reset_i = 1'b0;

                enable_sequence();
                controller_sweep();
                for (int s = 0; s < LOAD_ROWS; s++) begin
                        run_download(s);
                end

                $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                         uut.u_checker.assert_failures);
                if (errors == 0 && uut.u_checker.assert_failures == 0) begin
                        $display("Regression passed");
                end else begin
                        $display("Regression failed");
                end
                $finish;
        end

endmodule

//--- cv_io_core.f
hdl/cv_pkg.sv
hdl/cart_load_if.sv
hdl/ce_divider.sv
hdl/cart_loader_fsm.sv
hdl/cart_info.sv
hdl/cv_controller_encoder.sv
hdl/cv_io_core.sv
tests/cv_io_core_checker.sv
tests/cv_io_core_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module cv_io_core_tb -f cv_io_core.f

# Keep running past bound assertion errors so the closing summary is printed
out=$(./obj_dir/Vcv_io_core_tb +verilator+error+limit+1000 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Regression passed"
